/* tb.f */
+incdir+tb
hdl/dct_pkg.sv
hdl/dct_input_fold.sv
hdl/dct_even_part.sv
hdl/dct_odd_part.sv
hdl/dct_output_round.sv
hdl/dct_1d_col.sv
tb/dct_1d_col_tb.sv

/* tb/dct_ref_model.svh */
// Reference model of the column DCT with vector types, cosine weights and the bit cut
`ifndef DCT_REF_MODEL_SVH
`define DCT_REF_MODEL_SVH

// Sample and coefficient vectors, element n is sample n and element k is coefficient k
typedef sample_t [N_POINTS-1:0] sample_arr_t;
typedef coef_t   [N_POINTS-1:0] coef_arr_t;

// Weight of sample n in coefficient k
// Phase k(2n+1) on a 64-step circle, folded onto the quarter table
function automatic int cos_weight(input int k, input int n);
    int m;
    int w;
    m = (k * (2 * n + 1)) % 64;
    if (m <= 16) begin
        w = COS_C[m];
    end else if (m <= 32) begin
        w = -COS_C[32 - m];
    end else if (m <= 48) begin
        w = -COS_C[m - 32];
    end else begin
        w = COS_C[64 - m];
    end
    return w;
endfunction

// Twelve bits from lsb upward
// Clipped to the limits when they lose the sign of the full value
function automatic coef_t keep_bits(input int value, input int lsb, input bit clip);
    int    scaled;
    coef_t kept;
    scaled = value >>> lsb;
    kept   = scaled[COEF_W-1:0];
    if (clip && (kept[COEF_W-1] != (value < 0))) begin
        if (value < 0) begin
            kept = coef_t'(-(2 ** (COEF_W - 1)));
        end else begin
            kept = coef_t'(2 ** (COEF_W - 1) - 1);
        end
    end
    return kept;
endfunction

// Expected output coefficients for one input beat
function automatic coef_arr_t ref_coefs(input sample_arr_t x, input logic block_flag);
    coef_arr_t res;
    int        acc;
    // DC is the plain sum, scaled by the mode shift
    acc = 0;
    for (int n = 0; n < N_POINTS; n++) begin
        acc += int'(x[n]);
    end
    res[0] = keep_bits(acc, block_flag ? DC_SHIFT_BLOCK : DC_SHIFT_PLAIN, 1'b1);
    for (int k = 1; k < N_POINTS; k++) begin
        acc = 0;
        for (int n = 0; n < N_POINTS; n++) begin
            acc += int'(x[n]) * cos_weight(k, n);
        end
        // Coefficient 1 clips and the rest wrap
        res[k] = keep_bits(acc, CUT_LSB, k == 1);
    end
    return res;
endfunction

`endif

/* tb/dct_1d_col_tb.sv */
// Testbench for the column DCT with clock, reset, stimulus, output checks, timeout and report
`default_nettype none

module dct_1d_col_tb;
    import dct_pkg::*;

    `include "dct_ref_model.svh"

    // Run limit, three cycles per random vector plus margin
    localparam int N_RANDOM   = 300;
    localparam int MAX_CYCLES = 3 * N_RANDOM + 20;

    // Sample limits
    localparam sample_t S_MAX     = sample_t'(1023);
    localparam sample_t S_MIN     = sample_t'(-1024);
    localparam sample_t S_NEG_MAX = sample_t'(-1023);

    logic        clk;
    logic        reset;
    sample_vec_t in_beat;
    coef_vec_t   out_beat;

    int seed          = 27428;
    int cycle_count   = 0;
    int sent_count    = 0;
    int checked_count = 0;

    // Expected output beats in input order
    coef_arr_t expect_q [$];

    // Expected valid behind the input register and the output register
    logic exp_fold_valid = 1'b0;
    logic exp_out_valid  = 1'b0;
    logic armed          = 1'b0;

    dct_1d_col dut0 (
        .clk      (clk),
        .reset    (reset),
        .in_beat  (in_beat),
        .out_beat (out_beat)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1);
    endtask

    // One beat per falling edge, valid stays high for back-to-back beats
    task automatic send_beat(input sample_arr_t vec, input logic flag);
        @(negedge clk);
        in_beat.valid      = 1'b1;
        in_beat.block_flag = flag;
        in_beat.samples    = vec;
        expect_q.push_back(ref_coefs(vec, flag));
        sent_count++;
    endtask

    task automatic idle_cycles(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            in_beat.valid = 1'b0;
        end
    endtask

    // Full-range random samples
    function automatic sample_arr_t random_vector();
        sample_arr_t vec;
        int          r;
        for (int n = 0; n < N_POINTS; n++) begin
            r      = $random(seed);
            vec[n] = sample_t'(r);
        end
        return vec;
    endfunction

    // Split puts a in the lower half and b in the upper half
    // Otherwise a on even samples and b on odd samples
    function automatic sample_arr_t pattern_vector(input sample_t a, input sample_t b,
                                                   input bit split);
        sample_arr_t vec;
        for (int n = 0; n < N_POINTS; n++) begin
            if (split) begin
                vec[n] = (n < N_HALF) ? a : b;
            end else begin
                vec[n] = (n % 2 == 1) ? b : a;
            end
        end
        return vec;
    endfunction

    // Output checks on registered values, read before this edge updates them
    always @(posedge clk) begin
        coef_arr_t expected;
        if (armed) begin
            assert (out_beat.valid === exp_out_valid) else begin
                fail_now($sformatf("MISMATCH out_beat.valid expected %h actual %h",
                                   exp_out_valid, out_beat.valid));
            end
            if (out_beat.valid) begin
                expected = expect_q.pop_front();
                checked_count++;
                for (int k = 0; k < N_POINTS; k++) begin
                    assert (out_beat.coef[k] === expected[k]) else begin
                        fail_now($sformatf("MISMATCH out_beat.coef[%0d] expected %h actual %h",
                                           k, expected[k], out_beat.coef[k]));
                    end
                end
            end
        end
        // Valid pipeline after this edge
        exp_out_valid  = reset ? 1'b0 : exp_fold_valid;
        exp_fold_valid = reset ? 1'b0 : in_beat.valid;
        if (reset) begin
            armed = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            fail_now($sformatf("Timeout after %0d cycles with %0d of %0d beats checked",
                               cycle_count, checked_count, sent_count));
        end
    end

    initial begin
        sample_arr_t vec;
        logic        flag;
        in_beat = '0;
        reset   = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Reset exit with no input, output valid stays low
        idle_cycles(3);

        // Random vectors, back-to-back at first and then with random gaps
        for (int i = 0; i < N_RANDOM; i++) begin
            if (i > 20 && ($random(seed) & 7) == 0) begin
                idle_cycles(1);
            end
            vec  = random_vector();
            flag = ($random(seed) & 1) != 0;
            send_beat(vec, flag);
        end
        idle_cycles(2);

        // Same vector in plain and block mode
        vec = random_vector();
        send_beat(vec, 1'b0);
        send_beat(vec, 1'b1);
        idle_cycles(2);

        // Constant limits clip the DC in plain mode
        send_beat(pattern_vector(S_MAX, S_MAX, 1'b0), 1'b0);
        send_beat(pattern_vector(S_MIN, S_MIN, 1'b0), 1'b0);
        send_beat(pattern_vector(S_MAX, S_MAX, 1'b0), 1'b1);
        send_beat(pattern_vector(S_MIN, S_MIN, 1'b0), 1'b1);
        // Halves at opposite limits push coefficient 1 past 12 bits
        send_beat(pattern_vector(S_MAX, S_MIN, 1'b1), 1'b0);
        send_beat(pattern_vector(S_MIN, S_MAX, 1'b1), 1'b0);
        idle_cycles(1);

        // Alternating signs, both phases and both modes
        send_beat(pattern_vector(S_MAX, S_NEG_MAX, 1'b0), 1'b0);
        send_beat(pattern_vector(S_NEG_MAX, S_MAX, 1'b0), 1'b0);
        send_beat(pattern_vector(S_MAX, S_NEG_MAX, 1'b0), 1'b1);
        send_beat(pattern_vector(S_NEG_MAX, S_MAX, 1'b0), 1'b1);
        idle_cycles(1);

        // Drain, then output stays quiet
        while (expect_q.size() != 0) begin
            @(negedge clk);
        end
        idle_cycles(3);

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/dct_1d_col.sv */
// Top level of the 16-point column DCT, input fold, even and odd parts, output round
`default_nettype none

module dct_1d_col (
    input  logic                 clk,
    input  logic                 reset,
    input  dct_pkg::sample_vec_t in_beat,
    output dct_pkg::coef_vec_t   out_beat
);
    import dct_pkg::*;

    // Registered first fold, shared by both halves
    fold_t     fold;
    // Raw results ahead of the cut
    even_raw_t even_raw;
    odd_raw_t  odd_raw;

    // Stage 1, registered
    dct_input_fold u_input_fold (
        .clk     (clk),
        .reset   (reset),
        .in_beat (in_beat),
        .fold    (fold)
    );

    // Combinational even half
    dct_even_part u_even_part (
        .fold     (fold),
        .even_raw (even_raw)
    );

    // Combinational odd half
    dct_odd_part u_odd_part (
        .fold    (fold),
        .odd_raw (odd_raw)
    );

    // Stage 2, registered output beat
    dct_output_round u_output_round (
        .clk      (clk),
        .reset    (reset),
        .fold     (fold),
        .even_raw (even_raw),
        .odd_raw  (odd_raw),
        .out_beat (out_beat)
    );

endmodule

`default_nettype wire

/* hdl/dct_output_round.sv */
// DC scaling, bit cut, saturation and the output register
`default_nettype none

module dct_output_round (
    input  logic               clk,
    input  logic               reset,
    input  dct_pkg::fold_t     fold,
    input  dct_pkg::even_raw_t even_raw,
    input  dct_pkg::odd_raw_t  odd_raw,
    output dct_pkg::coef_vec_t out_beat
);
    import dct_pkg::*;

    // Clip to the 12-bit limit when the cut lost the sign of the raw value
    function automatic coef_t sat_cut(input coef_t cut, input logic raw_sign);
        coef_t res;
        if (cut[COEF_W-1] != raw_sign) begin
            res = raw_sign ? {1'b1, {(COEF_W-1){1'b0}}} : {1'b0, {(COEF_W-1){1'b1}}};
        end else begin
            res = cut;
        end
        return res;
    endfunction

    raw_t                  dc_shifted;
    coef_t [N_POINTS-1:0]  coef_next;

    // Arithmetic shift keeps the DC sign
    assign dc_shifted = fold.block_flag ? (even_raw.coef[0] >>> DC_SHIFT_BLOCK)
                                        : (even_raw.coef[0] >>> DC_SHIFT_PLAIN);

    always_comb begin
        // DC keeps the low bits after the shift
        coef_next[0] = sat_cut(dc_shifted[COEF_W-1:0], even_raw.coef[0][RAW_W-1]);
        // Coefficient 1 saturates like the DC
        coef_next[1] = sat_cut(odd_raw.coef[0][CUT_MSB:CUT_LSB], odd_raw.coef[0][RAW_W-1]);
        for (int j = 1; j < N_HALF; j++) begin
            // Remaining terms wrap
            coef_next[2*j]   = even_raw.coef[j][CUT_MSB:CUT_LSB];
            coef_next[2*j+1] = odd_raw.coef[j][CUT_MSB:CUT_LSB];
        end
    end

    always_ff @(posedge clk) begin
        out_beat.coef <= coef_next;
        if (reset) begin
            out_beat.valid <= 1'b0;
        end else begin
            out_beat.valid <= fold.valid;
        end
    end

endmodule

`default_nettype wire

/* hdl/dct_odd_part.sv */
// Constant-product accumulation producing raw coefficients 1, 3, 5, 7, 9, 11, 13 and 15
`default_nettype none

module dct_odd_part (
    input  dct_pkg::fold_t    fold,
    output dct_pkg::odd_raw_t odd_raw
);
    import dct_pkg::*;

    // Signed cosine weight of difference n for coefficient k
    // Phase m = k(2n+1) mod 64 is folded back onto the first quarter
    function automatic logic signed [7:0] fold_weight(input int k, input int n);
        int                m;
        logic signed [7:0] w;
        m = (k * (2 * n + 1)) % 64;
        if (m <= 16) begin
            // First quarter, positive
            w = COS_C[m];
        end else if (m <= 32) begin
            // Second quarter, mirrored and negated
            w = -COS_C[32 - m];
        end else if (m <= 48) begin
            // Third quarter, negated
            w = -COS_C[m - 32];
        end else begin
            // Fourth quarter, mirrored
            w = COS_C[64 - m];
        end
        return w;
    endfunction

    // Products of each difference with its weight, one row per coefficient
    raw_t prod [0:N_HALF-1][0:N_HALF-1];

    always_comb begin
        for (int i = 0; i < N_HALF; i++) begin
            for (int n = 0; n < N_HALF; n++) begin
                // Both operands signed, extended to raw width before the product
                prod[i][n] = raw_t'(fold.diff[n]) * raw_t'(fold_weight(2 * i + 1, n));
            end
        end
    end

    // Sum of eight products per coefficient
    always_comb begin
        raw_t acc;
        for (int i = 0; i < N_HALF; i++) begin
            acc = '0;
            for (int n = 0; n < N_HALF; n++) begin
                acc = acc + prod[i][n];
            end
            // Worst case stays below 2^20, no wrap at raw width
            odd_raw.coef[i] = acc;
        end
    end

endmodule

`default_nettype wire

/* hdl/dct_even_part.sv */
// Even butterfly tree producing raw coefficients 0, 2, 4, 6, 8, 10, 12 and 14
`default_nettype none

module dct_even_part (
    input  dct_pkg::fold_t    fold,
    output dct_pkg::even_raw_t even_raw
);
    import dct_pkg::*;

    // Second fold of the sums, pairs n and 7-n
    logic signed [STAGE2_W-1:0] ev_sum [0:3];
    logic signed [STAGE2_W-1:0] ev_dif [0:3];

    // Third fold, even-even part
    logic signed [STAGE3_W-1:0] ee_sum_a;
    logic signed [STAGE3_W-1:0] ee_sum_b;
    logic signed [STAGE3_W-1:0] ee_dif_a;
    logic signed [STAGE3_W-1:0] ee_dif_b;

    // Fourth fold, DC and coefficient 8
    logic signed [STAGE4_W-1:0] dc_sum;
    logic signed [STAGE4_W-1:0] c8_dif;

    always_comb begin
        for (int n = 0; n < 4; n++) begin
            ev_sum[n] = fold.sum[n] + fold.sum[N_HALF-1-n];
            ev_dif[n] = fold.sum[n] - fold.sum[N_HALF-1-n];
        end
    end

    // Groups {0,3,4,7} against {1,2,5,6} of the first-fold sums
    assign ee_sum_a = ev_sum[0] + ev_sum[3];
    assign ee_sum_b = ev_sum[1] + ev_sum[2];
    assign ee_dif_a = ev_sum[0] - ev_sum[3];
    assign ee_dif_b = ev_sum[1] - ev_sum[2];

    assign dc_sum = ee_sum_a + ee_sum_b;
    assign c8_dif = ee_sum_a - ee_sum_b;

    always_comb begin
        // Plain sum of all sixteen samples, scaled later
        even_raw.coef[0] = dc_sum;

        // Coefficient 8, single constant
        even_raw.coef[4] = c8_dif * COS_C[8];

        // Coefficients 4 and 12, rotation by C4 and C12
        even_raw.coef[2] = COS_C[4]  * ee_dif_a + COS_C[12] * ee_dif_b;
        even_raw.coef[6] = COS_C[12] * ee_dif_a - COS_C[4]  * ee_dif_b;

        // Coefficients 2, 6, 10 and 14 from the even-odd differences
        even_raw.coef[1] = COS_C[2]  * ev_dif[0] + COS_C[6]  * ev_dif[1]
                         + COS_C[10] * ev_dif[2] + COS_C[14] * ev_dif[3];
        even_raw.coef[3] = COS_C[6]  * ev_dif[0] - COS_C[14] * ev_dif[1]
                         - COS_C[2]  * ev_dif[2] - COS_C[10] * ev_dif[3];
        even_raw.coef[5] = COS_C[10] * ev_dif[0] - COS_C[2]  * ev_dif[1]
                         + COS_C[14] * ev_dif[2] + COS_C[6]  * ev_dif[3];
        // Last term lands on m = 34, hence the sign flip on C2
        even_raw.coef[7] = COS_C[14] * ev_dif[0] - COS_C[10] * ev_dif[1]
                         + COS_C[6]  * ev_dif[2] - COS_C[2]  * ev_dif[3];
    end

endmodule

`default_nettype wire

/* hdl/dct_input_fold.sv */
// Input register and first butterfly fold into eight sums and eight differences
`default_nettype none

module dct_input_fold (
    input  logic                 clk,
    input  logic                 reset,
    input  dct_pkg::sample_vec_t in_beat,
    output dct_pkg::fold_t       fold
);
    import dct_pkg::*;

    // Registered input beat
    sample_vec_t beat_q;

    always_ff @(posedge clk) begin
        // Payload captured every cycle
        beat_q.samples    <= in_beat.samples;
        beat_q.block_flag <= in_beat.block_flag;
        if (reset) begin
            beat_q.valid <= 1'b0;
        end else begin
            beat_q.valid <= in_beat.valid;
        end
    end

    // Mirror pairs around the vector centre
    always_comb begin
        fold.valid      = beat_q.valid;
        fold.block_flag = beat_q.block_flag;
        for (int n = 0; n < N_HALF; n++) begin
            // One bit of growth, sign extended by the 12-bit context
            fold.sum[n]  = beat_q.samples[n] + beat_q.samples[N_POINTS-1-n];
            fold.diff[n] = beat_q.samples[n] - beat_q.samples[N_POINTS-1-n];
        end
    end

endmodule

`default_nettype wire

/* hdl/dct_pkg.sv */
// Widths, cosine constants, cut positions and beat types of the 16-point column DCT
`default_nettype none

package dct_pkg;

    // Vector geometry
    localparam int N_POINTS = 16;
    localparam int N_HALF   = N_POINTS / 2;

    // Sample and coefficient widths
    localparam int SAMPLE_W = 11;
    localparam int COEF_W   = 12;
    localparam int RAW_W    = 21;

    // Butterfly stage widths, one bit of growth per fold
    localparam int FOLD_W   = SAMPLE_W + 1;
    localparam int STAGE2_W = FOLD_W + 1;
    localparam int STAGE3_W = FOLD_W + 2;
    localparam int STAGE4_W = FOLD_W + 3;

    // Raw bits kept for the coefficient, 12 bits with 5 fraction bits dropped
    localparam int CUT_LSB = 5;
    localparam int CUT_MSB = 16;

    // DC right shifts for block and plain mode
    localparam int DC_SHIFT_BLOCK = 3;
    localparam int DC_SHIFT_PLAIN = 1;

    // Cosine constants in 1.6 fixed point
    // Index 16 is the zero crossing, used by the folding rule
    localparam logic signed [6:0] COS_C [0:16] = '{
        7'sd16, 7'sd23, 7'sd22, 7'sd22, 7'sd21, 7'sd20, 7'sd19, 7'sd17,
        7'sd16, 7'sd14, 7'sd13, 7'sd11, 7'sd9,  7'sd7,  7'sd4,  7'sd2,
        7'sd0
    };

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic signed [COEF_W-1:0]   coef_t;
    typedef logic signed [RAW_W-1:0]    raw_t;

    // One word of the first fold, sum or difference of a sample pair
    typedef logic signed [FOLD_W-1:0]   fold_word_t;

    // Input beat, samples[n] is sample n
    typedef struct packed {
        logic                        valid;
        logic                        block_flag;
        sample_t [N_POINTS-1:0]      samples;
    } sample_vec_t;

    // First fold, sum[n] = x[n] + x[15-n], diff[n] = x[n] - x[15-n]
    typedef struct packed {
        logic                        valid;
        logic                        block_flag;
        fold_word_t [N_HALF-1:0]     sum;
        fold_word_t [N_HALF-1:0]     diff;
    } fold_t;

    // coef[j] holds raw coefficient 2j
    typedef struct packed {
        raw_t [N_HALF-1:0]           coef;
    } even_raw_t;

    // coef[j] holds raw coefficient 2j+1
    typedef struct packed {
        raw_t [N_HALF-1:0]           coef;
    } odd_raw_t;

    // Output beat, coef[k] is coefficient k
    typedef struct packed {
        logic                        valid;
        coef_t [N_POINTS-1:0]        coef;
    } coef_vec_t;

endpackage

`default_nettype wire
